/* logic/pad_consts.svh */
//////////////////////////////////////////////////
// Controller port constants
// Joystick and shift widths, port count,
// multitap signatures and microphone duty limits
//////////////////////////////////////////////////

`ifndef PAD_CONSTS_SVH
`define PAD_CONSTS_SVH

// Host joystick word
`define PAD_JOY_WIDTH 23

// Serial port shift register
`define PAD_PORT_BITS 24	// Button byte plus two multitap bytes
`define PAD_NUM_PORTS 2

//////////////////////////////////////////////////
// Multitap signature bytes
//////////////////////////////////////////////////

`define PAD_SIG_PORT1 8'h08	// Follows joystick C
`define PAD_SIG_PORT2 8'h04	// Follows joystick D

//////////////////////////////////////////////////
// Microphone duty counter
//////////////////////////////////////////////////

// Counter runs 0..PAD_MIC_WRAP, then back to zero
`define PAD_MIC_WRAP 250

// Mic passes while the counter is below this
`define PAD_MIC_ON 215

`endif

/* logic/pad_pkg.sv */
//////////////////////////////////////////////////
// Controller port types
// Joystick word, console bus, port word, power pad
//////////////////////////////////////////////////

`include "pad_consts.svh"

package pad_pkg;

	// Joystick bits left over after buttons, mic, fds and trigger
	localparam int pp_bits = `PAD_JOY_WIDTH - 11;

	// One host joystick, first field is the MSB
	typedef struct packed {
		logic [pp_bits-1:0] powerpad;	// Twelve power-pad mats
		logic trigger;	// Carried, not used by the ports
		logic mic;
		logic fds;	// Disk button, carried only
		logic [3:0] face;	// A, B, select, start from bit 0
		logic [3:0] dpad;	// Right, left, down, up from bit 0
	} joy_in_t;

	// Console read bus
	typedef struct packed {
		logic strobe;
		logic [1:0] port_clock;	// Bit 0 is port 1
	} pad_bus_t;

	// Load value of one serial port, shifted out LSB first
	typedef struct packed {
		logic [7:0] sig_byte;	// Multitap signature or ones
		logic [7:0] ext_byte;	// Joystick C/D or ones
		logic [7:0] btn_byte;	// First byte the console reads
	} port_word_t;

	// Power-pad serial bytes
	typedef struct packed {
		logic [7:0] d4;
		logic [7:0] d3;
	} powerpad_load_t;

endpackage

/* logic/pad_mapper.sv */
//////////////////////////////////////////////////
// Joystick to port mapper
// Button reorder, A/B swap, multitap bytes and
// power-pad merge for both serial ports
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pad_consts.svh"

module pad_mapper (
	input  pad_pkg::joy_in_t joy_a,
	input  pad_pkg::joy_in_t joy_b,
	input  pad_pkg::joy_in_t joy_c,
	input  pad_pkg::joy_in_t joy_d,
	input  logic multitap_en,
	input  logic swap_en,
	output pad_pkg::port_word_t port_words [`PAD_NUM_PORTS],
	output pad_pkg::powerpad_load_t pp_load
);

	import pad_pkg::*;

	// Signature appended per port in multitap mode
	localparam logic [7:0] sig_bytes [`PAD_NUM_PORTS] = '{`PAD_SIG_PORT1, `PAD_SIG_PORT2};

	// Console order, A goes out first and right last
	function automatic logic [7:0] button_byte(input joy_in_t joy);
		return {
			joy.dpad[0],	// Right
			joy.dpad[1],	// Left
			joy.dpad[2],	// Down
			joy.dpad[3],	// Up
			joy.face[3],	// Start
			joy.face[2],	// Select
			joy.face[1],	// B
			joy.face[0]	// A
		};
	endfunction

	joy_in_t main_pad [`PAD_NUM_PORTS];	// A/B pair after swap
	joy_in_t tap_pad [`PAD_NUM_PORTS];	// C and D on the multitap
	logic [pp_bits-1:0] pp_merged;

	//////////////////////////////////////////////////
	// Port words
	//////////////////////////////////////////////////

	always_comb begin
		main_pad[0] = swap_en ? joy_b : joy_a;
		main_pad[1] = swap_en ? joy_a : joy_b;
		tap_pad[0] = joy_c;
		tap_pad[1] = joy_d;

		for (int p = 0; p < `PAD_NUM_PORTS; p++) begin
			port_words[p].btn_byte = button_byte(main_pad[p]);
			if (multitap_en) begin
				port_words[p].ext_byte = button_byte(tap_pad[p]);
				port_words[p].sig_byte = sig_bytes[p];
			end else begin
				// Plain pad reads ones after its eight buttons
				port_words[p].ext_byte = 8'hff;
				port_words[p].sig_byte = 8'hff;
			end
		end
	end

	//////////////////////////////////////////////////
	// Power pad
	//////////////////////////////////////////////////

	// Any joystick may carry the mat
	assign pp_merged = joy_a.powerpad | joy_b.powerpad | joy_c.powerpad | joy_d.powerpad;

	// Mat scramble as the console expects it
	assign pp_load.d4 = {
		4'b0000,
		pp_merged[7],
		pp_merged[11],
		pp_merged[2],
		pp_merged[3]
	};

	assign pp_load.d3 = {
		pp_merged[6],
		pp_merged[10],
		pp_merged[9],
		pp_merged[5],
		pp_merged[8],
		pp_merged[4],
		pp_merged[0],
		pp_merged[1]
	};

endmodule

/* logic/port_shifter.sv */
//////////////////////////////////////////////////
// Serial joypad port
// Parallel load on strobe, shift on falling
// port clock, shift pulse for the merge stage
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pad_consts.svh"

module port_shifter (
	input  logic clk,
	input  logic reset_nes,
	input  logic strobe,
	input  logic port_clock,
	input  pad_pkg::port_word_t load_word,
	output logic serial_bit,
	output logic shift_pulse
);

	import pad_pkg::*;

	logic [`PAD_PORT_BITS-1:0] shift_reg;
	logic prev_clock;	// Port clock from the last edge
	logic clock_fall;

	// High for one cycle, the first edge that sees the clock low
	assign clock_fall = prev_clock & ~port_clock;

	//////////////////////////////////////////////////
	// Shift register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shift_reg <= '0;
			prev_clock <= 1'b0;
		end else begin
			prev_clock <= port_clock;

			// Strobe holds the register at the load value
			if (strobe) begin
				shift_reg <= load_word;
			end else if (clock_fall) begin
				shift_reg <= {1'b0, shift_reg[`PAD_PORT_BITS-1:1]};	// Zeros after the last bit
			end
		end
	end

	// Console sees the LSB straight from the register
	assign serial_bit = shift_reg[0];

	// Power pad on port 2 follows this edge
	assign shift_pulse = clock_fall;

endmodule

/* logic/port_merge.sv */
//////////////////////////////////////////////////
// Port data merge
// Power-pad shift registers, microphone duty
// counter and the four-bit console data lines
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pad_consts.svh"

module port_merge (
	input  logic clk,
	input  logic reset_nes,
	input  logic strobe,
	input  logic [`PAD_NUM_PORTS-1:0] port_bits,
	input  logic port2_shift,
	input  pad_pkg::powerpad_load_t pp_load,
	input  logic [1:0] mic_buttons,	// Mic bits of joysticks A and B
	output logic [3:0] joy_data,
	output logic mic
);

	import pad_pkg::*;

	localparam int mic_cnt_bits = $clog2(`PAD_MIC_WRAP + 1);

	powerpad_load_t pp_shift;	// Live d3/d4 registers
	logic [mic_cnt_bits-1:0] mic_cnt;
	logic mic_window;

	//////////////////////////////////////////////////
	// Power-pad shift registers
	//////////////////////////////////////////////////

	// Clocked out alongside port 2
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			pp_shift <= '0;
		end else if (strobe) begin
			pp_shift <= pp_load;
		end else if (port2_shift) begin
			pp_shift.d3 <= {1'b0, pp_shift.d3[7:1]};
			pp_shift.d4 <= {1'b0, pp_shift.d4[7:1]};
		end
	end

	//////////////////////////////////////////////////
	// Microphone
	//////////////////////////////////////////////////

	// Free-running duty counter
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			mic_cnt <= '0;
		end else if (mic_cnt == mic_cnt_bits'(`PAD_MIC_WRAP)) begin
			mic_cnt <= '0;
		end else begin
			mic_cnt <= mic_cnt + 1'b1;
		end
	end

	assign mic_window = (mic_cnt < mic_cnt_bits'(`PAD_MIC_ON));	// On part of the period

	// Either front pad may hold the mic
	assign mic = mic_window & (|mic_buttons);

	// Data lines
	// Zapper light and trigger slots carry the power pad
	assign joy_data = {
		pp_shift.d4[0],
		pp_shift.d3[0],
		port_bits[1],
		port_bits[0]
	};

endmodule

/* logic/controller_ports.sv */
//////////////////////////////////////////////////
// Controller port top level
// Mapper, two serial port shifters, merge stage
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pad_consts.svh"

module controller_ports (
	input  logic clk,
	input  logic reset_nes,
	input  pad_pkg::joy_in_t joy_a,
	input  pad_pkg::joy_in_t joy_b,
	input  pad_pkg::joy_in_t joy_c,
	input  pad_pkg::joy_in_t joy_d,
	input  logic multitap_en,
	input  logic swap_en,
	input  pad_pkg::pad_bus_t pad_bus,	// Strobe and port clocks from the console
	output logic [3:0] joy_data,
	output logic mic
);

	import pad_pkg::*;

	port_word_t port_words [`PAD_NUM_PORTS];
	powerpad_load_t pp_load;
	logic [`PAD_NUM_PORTS-1:0] port_bits;	// Serial LSB of each port
	logic [`PAD_NUM_PORTS-1:0] shift_pulses;

	//////////////////////////////////////////////////
	// Load words
	//////////////////////////////////////////////////

	pad_mapper mapper (
		.joy_a       (joy_a),
		.joy_b       (joy_b),
		.joy_c       (joy_c),
		.joy_d       (joy_d),
		.multitap_en (multitap_en),
		.swap_en     (swap_en),
		.port_words  (port_words),
		.pp_load     (pp_load)
	);

	//////////////////////////////////////////////////
	// Serial ports
	//////////////////////////////////////////////////

	generate
		for (genvar p = 0; p < `PAD_NUM_PORTS; p++) begin : g_port
			// Each port runs off its own clock bit
			port_shifter shifter (
				.clk         (clk),
				.reset_nes   (reset_nes),
				.strobe      (pad_bus.strobe),
				.port_clock  (pad_bus.port_clock[p]),
				.load_word   (port_words[p]),
				.serial_bit  (port_bits[p]),
				.shift_pulse (shift_pulses[p])
			);
		end
	endgenerate

	//////////////////////////////////////////////////
	// Data lines and mic
	//////////////////////////////////////////////////

	port_merge merge (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.strobe      (pad_bus.strobe),
		.port_bits   (port_bits),
		.port2_shift (shift_pulses[1]),	// Power pad rides on port 2
		.pp_load     (pp_load),
		.mic_buttons ({joy_b.mic, joy_a.mic}),
		.joy_data    (joy_data),
		.mic         (mic)
	);

endmodule

/* bench/controller_ports_assertions.sv */
//////////////////////////////////////////////////
// Controller port assertions
// Reset state, load and shift timing, mic gating
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pad_consts.svh"

module controller_ports_assertions (
	input  logic clk,
	input  logic reset_nes,
	input  pad_pkg::joy_in_t joy_a,
	input  pad_pkg::joy_in_t joy_b,
	input  pad_pkg::pad_bus_t pad_bus,
	input  logic port2_shift,	// Shift pulse of port 2
	input  logic [`PAD_NUM_PORTS-1:0] load_lsbs,	// LSB of each port word
	input  logic [7:0] pp_d3,	// Live d3 register
	input  logic [3:0] joy_data,
	input  logic mic
);

	import pad_pkg::*;

	int fail_count = 0;	// Read by the testbench

	//////////////////////////////////////////////////
	// Reset and mic
	//////////////////////////////////////////////////

	// Registers clear on the first reset edge and stay clear
	reset_clears: assert property (@(posedge clk)
		reset_nes |=> (joy_data == 4'h0) && !mic)
	else begin
		fail_count++;
		$error("joy_data or mic not cleared by reset");
	end

	// Duty window alone never raises mic
	mic_needs_button: assert property (@(posedge clk)
		mic |-> (joy_a.mic || joy_b.mic))
	else begin
		fail_count++;
		$error("mic high with no mic button held");
	end

	//////////////////////////////////////////////////
	// Load and shift
	//////////////////////////////////////////////////

	// Strobe puts both word LSBs on the data lines
	strobe_loads: assert property (@(posedge clk) disable iff (reset_nes)
		pad_bus.strobe |=> joy_data[1:0] == $past(load_lsbs))
	else begin
		fail_count++;
		$error("port data after strobe differs from load word");
	end

	// Power pad moves one bit per port 2 shift
	pp_shift_rule: assert property (@(posedge clk) disable iff (reset_nes)
		(port2_shift && !pad_bus.strobe) |=> joy_data[2] == $past(pp_d3[1]))
	else begin
		fail_count++;
		$error("d3 bit did not advance on port 2 shift");
	end

endmodule

bind controller_ports controller_ports_assertions checks (
	.clk          (clk),
	.reset_nes    (reset_nes),
	.joy_a        (joy_a),
	.joy_b        (joy_b),
	.pad_bus      (pad_bus),
	.port2_shift  (shift_pulses[1]),
	.load_lsbs    ({port_words[1].btn_byte[0], port_words[0].btn_byte[0]}),
	.pp_d3        (merge.pp_shift.d3),
	.joy_data     (joy_data),
	.mic          (mic)
);

/* bench/tb_controller_ports.sv */
//////////////////////////////////////////////////
// Controller ports testbench
// Clock, reset, pad stimulus, serial readout,
// per-test report and watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pad_consts.svh"

module tb_controller_ports;

	import pad_pkg::*;

	localparam int num_tests = 6;
	localparam int read_len = 32;	// One byte past the port word
	localparam int watchdog_cycles = num_tests * 40 * 4 + 500;
	localparam int mic_cycles = 502;

	// Mat bit behind each power-pad data bit, LSB first
	localparam int d3_order [8] = '{1, 0, 4, 8, 5, 9, 10, 6};
	localparam int d4_order [4] = '{3, 2, 11, 7};

	logic clk;
	logic reset_nes;
	joy_in_t joy_a;
	joy_in_t joy_b;
	joy_in_t joy_c;
	joy_in_t joy_d;
	logic multitap_en;
	logic swap_en;
	pad_bus_t pad_bus;
	logic [3:0] joy_data;
	logic mic;

	integer seed;
	int errors;
	int tests_run;
	int tests_failed;
	int test_start;
	int highs;

	controller_ports UUT (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.joy_a       (joy_a),
		.joy_b       (joy_b),
		.joy_c       (joy_c),
		.joy_d       (joy_d),
		.multitap_en (multitap_en),
		.swap_en     (swap_en),
		.pad_bus     (pad_bus),
		.joy_data    (joy_data),
		.mic         (mic)
	);

	always #5 clk = ~clk;

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, run stopped", watchdog_cycles);
		$display("Test failures found");
		$finish;
	end

	//////////////////////////////////////////////////
	// Expected values
	//////////////////////////////////////////////////

	// Serial order A, B, select, start, up, down, left, right
	function automatic logic [7:0] console_byte(input joy_in_t joy);
		logic [7:0] b;
		b[3:0] = joy.face;
		for (int k = 0; k < 4; k++) begin
			b[4 + k] = joy.dpad[3 - k];
		end
		return b;
	endfunction

	function automatic logic [23:0] expected_word(input int port);
		joy_in_t front;
		joy_in_t tap;
		logic [7:0] sig;
		front = ((port == 0) ^ swap_en) ? joy_a : joy_b;
		tap = (port == 0) ? joy_c : joy_d;
		sig = (port == 0) ? `PAD_SIG_PORT1 : `PAD_SIG_PORT2;
		if (multitap_en) begin
			return {sig, console_byte(tap), console_byte(front)};
		end
		return {16'hffff, console_byte(front)};
	endfunction

	function automatic logic [7:0] expected_pp(input bit upper);
		logic [11:0] mat;
		logic [7:0] b;
		mat = joy_a.powerpad | joy_b.powerpad | joy_c.powerpad | joy_d.powerpad;
		b = '0;
		for (int k = 0; k < 8; k++) begin
			if (!upper) begin
				b[k] = mat[d3_order[k]];
			end else if (k < 4) begin
				b[k] = mat[d4_order[k]];	// Top nibble of d4 stays zero
			end
		end
		return b;
	endfunction

	function automatic joy_in_t random_pad();
		logic [31:0] r;
		r = $random(seed);
		return r[`PAD_JOY_WIDTH-1:0];
	endfunction

	function automatic int total_failures();
		return errors + UUT.checks.fail_count;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////

	task automatic new_pads();
		@(negedge clk);
		joy_a = random_pad();
		joy_b = random_pad();
		joy_c = random_pad();
		joy_d = random_pad();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Strobe once, then clock both ports together
	task automatic read_ports(output logic [31:0] p1, output logic [31:0] p2,
		output logic [31:0] d3, output logic [31:0] d4);
		@(negedge clk);
		pad_bus.strobe = 1'b1;
		@(negedge clk);
		pad_bus.strobe = 1'b0;
		for (int i = 0; i < read_len; i++) begin
			@(negedge clk);
			p1[i] = joy_data[0];	// Sampled before the falling port clock
			p2[i] = joy_data[1];
			d3[i] = joy_data[2];
			d4[i] = joy_data[3];
			pad_bus.port_clock = 2'b00;
			@(negedge clk);
			pad_bus.port_clock = 2'b11;
		end
	endtask

	task automatic readout_check(input string tag);
		logic [31:0] p1;
		logic [31:0] p2;
		logic [31:0] d3;
		logic [31:0] d4;
		read_ports(p1, p2, d3, d4);
		check_value({"joy_data[0] ", tag}, p1, {8'h00, expected_word(0)});
		check_value({"joy_data[1] ", tag}, p2, {8'h00, expected_word(1)});
		check_value({"joy_data[2] ", tag}, d3, {24'h0, expected_pp(1'b0)});
		check_value({"joy_data[3] ", tag}, d4, {24'h0, expected_pp(1'b1)});
	endtask

	task automatic count_mic(input int cycles, output int high_cycles);
		high_cycles = 0;
		repeat (cycles) begin
			@(negedge clk);
			if (mic) begin
				high_cycles++;
			end
		end
	endtask

	task automatic end_test(input string name);
		int failed;
		failed = total_failures() - test_start;
		tests_run++;
		if (failed != 0) begin
			tests_failed++;
		end
		$display("Test %0d %s: %s, %0d errors", tests_run, name, (failed != 0) ? "FAIL" : "ok",
			failed);
		test_start = total_failures();
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		seed = 32'h5688;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_start = 0;
		clk = 1'b0;
		reset_nes = 1'b1;
		joy_a = '0;
		joy_b = '0;
		joy_c = '0;
		joy_d = '0;
		multitap_en = 1'b0;
		swap_en = 1'b0;
		pad_bus.strobe = 1'b0;
		pad_bus.port_clock = 2'b11;	// Console idles its clocks high

		repeat (16) @(posedge clk);
		@(negedge clk);
		reset_nes = 1'b0;
		@(negedge clk);
		check_value("joy_data", {28'h0, joy_data}, 32'h0);
		check_value("mic", {31'h0, mic}, 32'h0);
		end_test("reset");

		repeat (2) begin
			new_pads();
			readout_check("single");
		end
		end_test("single_pad");

		new_pads();
		swap_en = 1'b1;
		readout_check("swap");
		end_test("swap");

		new_pads();
		swap_en = 1'b0;
		multitap_en = 1'b1;
		readout_check("multitap");
		new_pads();
		swap_en = 1'b1;	// Multitap with the front pair swapped
		readout_check("multitap swap");
		end_test("multitap");

		// Mat only on joystick A so the OR leaves zeros to see
		new_pads();
		swap_en = 1'b0;
		multitap_en = 1'b0;
		joy_b.powerpad = '0;
		joy_c.powerpad = '0;
		joy_d.powerpad = '0;
		readout_check("powerpad");
		end_test("powerpad");

		@(negedge clk);
		joy_a.mic = 1'b0;
		joy_b.mic = 1'b0;
		count_mic(20, highs);
		check_value("mic high cycles, button off", highs, 32'h0);
		joy_a.mic = 1'b1;
		count_mic(mic_cycles, highs);
		check_value("mic high cycles", highs,
			(mic_cycles / (`PAD_MIC_WRAP + 1)) * `PAD_MIC_ON);
		joy_a.mic = 1'b0;
		end_test("microphone");

		repeat (2) @(negedge clk);	// Let trailing assertions settle
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_failures());
		if (total_failures() == 0 && tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+logic
logic/pad_pkg.sv
logic/pad_mapper.sv
logic/port_shifter.sv
logic/port_merge.sv
logic/controller_ports.sv
bench/controller_ports_assertions.sv
bench/tb_controller_ports.sv
